// ==== Makefile ====
TOP := scanAccessTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f scanAccess.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall --timing --assert -f scanAccess.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== common/scanCmdPkg.sv ====
`include "scan_defines.svh"

package scanCmdPkg;

        // host operations, one per strobe
        typedef enum logic [1:0] {
                opWrAddr = 2'd0,
                opWrData = 2'd1,
                opRdData = 2'd2
        } scanOpT;

        // address register contents of the target
        typedef logic [`SCAN_ADDR_LEN-1:0] addrT;

        // one data word, written or read back
        typedef logic [`SCAN_DATA_LEN-1:0] dataT;

endpackage

// ==== common/scanLinePkg.sv ====
`include "scan_defines.svh"

package scanLinePkg;

        // code bits as they appear on scanDo ahead of the payload
        typedef enum logic [`SCAN_CODE_LEN-1:0] {
                codeWrAddr = 2'b01,
                codeWrData = 2'b10,
                codeRdData = 2'b11
        } scanCodeT;

        // phases of one frame, shared by all three operations
        typedef enum logic [2:0] {
                phIdle      = 3'd0,
                phCode0     = 3'd1,
                phCode1     = 3'd2,
                phAddrShift = 3'd3,
                phDataShift = 3'd4,
                phEnd       = 3'd5,
                phDone      = 3'd6
        } framePhaseT;

endpackage

// ==== common/scan_defines.svh ====
`ifndef SCAN_DEFINES_SVH
`define SCAN_DEFINES_SVH

// address payload, shifted after the code bits of a write address frame
`define SCAN_ADDR_LEN 8

// data payload, shifted after the code bits of a write or read data frame
`define SCAN_DATA_LEN 16

// operation code that opens every frame, bit 0 first
`define SCAN_CODE_LEN 2

`endif

// ==== common/shiftCtrlIf.sv ====
`timescale 1ns/1ps

interface shiftCtrlIf;

        // copy the parallel value and clear the bit counter
        logic load;
        // shift one bit toward the lsb this cycle
        logic shiftEn;
        // bit entering at the msb
        logic serialIn;
        // current lsb of the register
        logic serialOut;
        // counter sits on the final bit of the payload
        logic lastBit;

        modport sequencer (
                output load,
                output shiftEn,
                output serialIn,
                input  serialOut,
                input  lastBit
        );

        modport shifter (
                input  load,
                input  shiftEn,
                input  serialIn,
                output serialOut,
                output lastBit
        );

endinterface

// ==== rtl/scanAccess.sv ====
`timescale 1ns/1ps

module scanAccess (
        input  logic                ICK,
        input  logic                RST,
        input  logic                cmdValid,
        input  scanCmdPkg::scanOpT  cmdOp,
        input  scanCmdPkg::addrT    cmdAddr,
        input  scanCmdPkg::dataT    cmdData,
        input  logic                scanDi,
        output logic                busy,
        output logic                doneValid,
        output scanCmdPkg::dataT    rspData,
        output logic                scanSel,
        output logic                scanDo
);

        // one control link per shifter
        shiftCtrlIf addrIf ();
        shiftCtrlIf dataIf ();

        scanSequencer sequencer (
                .ICK       (ICK),
                .RST       (RST),
                .cmdValid  (cmdValid),
                .cmdOp     (cmdOp),
                .scanDi    (scanDi),
                .addrCtrl  (addrIf.sequencer),
                .dataCtrl  (dataIf.sequencer),
                .busy      (busy),
                .doneValid (doneValid),
                .scanSel   (scanSel),
                .scanDo    (scanDo)
        );

        // the address value is kept only inside the shifter
        scanShifter #(
                .payloadT (scanCmdPkg::addrT)
        ) addrShifter (
                .ICK       (ICK),
                .RST       (RST),
                .ctrl      (addrIf.shifter),
                .loadValue (cmdAddr),
                .value     ()
        );

        // read replies are captured here and come out as rspData
        scanShifter #(
                .payloadT (scanCmdPkg::dataT)
        ) dataShifter (
                .ICK       (ICK),
                .RST       (RST),
                .ctrl      (dataIf.shifter),
                .loadValue (cmdData),
                .value     (rspData)
        );

endmodule

// ==== rtl/scanSequencer.sv ====
`timescale 1ns/1ps

module scanSequencer (
        input  logic                 ICK,
        input  logic                 RST,
        input  logic                 cmdValid,
        input  scanCmdPkg::scanOpT   cmdOp,
        input  logic                 scanDi,
        shiftCtrlIf.sequencer        addrCtrl,
        shiftCtrlIf.sequencer        dataCtrl,
        output logic                 busy,
        output logic                 doneValid,
        output logic                 scanSel,
        output logic                 scanDo
);

        scanLinePkg::framePhaseT phase;
        scanLinePkg::framePhaseT phaseNext;
        scanCmdPkg::scanOpT      opQ;
        scanLinePkg::scanCodeT   lineCode;
        logic                    accept;

        // a strobe only counts while idle, later ones are dropped
        assign accept = (phase == scanLinePkg::phIdle) && cmdValid;

        // phase register and latched operation
        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        phase <= scanLinePkg::phIdle;
                        opQ   <= scanCmdPkg::opWrAddr;
                end else begin
                        phase <= phaseNext;
                        if (accept) begin
                                opQ <= cmdOp;
                        end
                end
        end

        always_comb begin
                phaseNext = scanLinePkg::phIdle;
                case (phase)
                        scanLinePkg::phIdle: begin
                                phaseNext = cmdValid ? scanLinePkg::phCode0
                                                     : scanLinePkg::phIdle;
                        end
                        scanLinePkg::phCode0: begin
                                phaseNext = scanLinePkg::phCode1;
                        end
                        scanLinePkg::phCode1: begin
                                // payload kind follows from the operation
                                if (opQ == scanCmdPkg::opWrAddr) begin
                                        phaseNext = scanLinePkg::phAddrShift;
                                end else begin
                                        phaseNext = scanLinePkg::phDataShift;
                                end
                        end
                        scanLinePkg::phAddrShift: begin
                                phaseNext = addrCtrl.lastBit ? scanLinePkg::phEnd
                                                             : scanLinePkg::phAddrShift;
                        end
                        scanLinePkg::phDataShift: begin
                                phaseNext = dataCtrl.lastBit ? scanLinePkg::phEnd
                                                             : scanLinePkg::phDataShift;
                        end
                        scanLinePkg::phEnd: begin
                                phaseNext = scanLinePkg::phDone;
                        end
                        scanLinePkg::phDone: begin
                                phaseNext = scanLinePkg::phIdle;
                        end
                        default: begin
                                phaseNext = scanLinePkg::phIdle;
                        end
                endcase
        end

        // line code for the latched operation
        always_comb begin
                case (opQ)
                        scanCmdPkg::opWrAddr: lineCode = scanLinePkg::codeWrAddr;
                        scanCmdPkg::opWrData: lineCode = scanLinePkg::codeWrData;
                        default:              lineCode = scanLinePkg::codeRdData;
                endcase
        end

        // shifter control, loads happen in the accepting cycle
        assign addrCtrl.load    = accept && (cmdOp == scanCmdPkg::opWrAddr);
        assign dataCtrl.load    = accept && (cmdOp != scanCmdPkg::opWrAddr);
        assign addrCtrl.shiftEn = (phase == scanLinePkg::phAddrShift);
        assign dataCtrl.shiftEn = (phase == scanLinePkg::phDataShift);

        // address word rotates so the shifter keeps it after the frame
        assign addrCtrl.serialIn = addrCtrl.serialOut;
        // read reply enters the data shifter in the same cycle it is driven
        assign dataCtrl.serialIn = scanDi;

        // select is high for the code bits and the payload only
        assign scanSel = (phase == scanLinePkg::phCode0)
                      || (phase == scanLinePkg::phCode1)
                      || (phase == scanLinePkg::phAddrShift)
                      || (phase == scanLinePkg::phDataShift);

        always_comb begin
                case (phase)
                        scanLinePkg::phCode0:     scanDo = lineCode[0];
                        scanLinePkg::phCode1:     scanDo = lineCode[1];
                        scanLinePkg::phAddrShift: scanDo = addrCtrl.serialOut;
                        scanLinePkg::phDataShift: begin
                                // nothing meaningful goes out while the target replies
                                scanDo = (opQ == scanCmdPkg::opRdData) ? 1'b0
                                                                       : dataCtrl.serialOut;
                        end
                        default:                  scanDo = 1'b0;
                endcase
        end

        assign busy      = (phase != scanLinePkg::phIdle);
        assign doneValid = (phase == scanLinePkg::phDone);

endmodule

// ==== rtl/scanShifter.sv ====
`timescale 1ns/1ps

module scanShifter #(
        parameter type payloadT = logic [7:0]
) (
        input  logic          ICK,
        input  logic          RST,
        shiftCtrlIf.shifter   ctrl,
        input  payloadT       loadValue,
        output payloadT       value
);

        localparam int Width    = $bits(payloadT);
        localparam int CntWidth = (Width > 1) ? $clog2(Width) : 1;
        localparam logic [CntWidth-1:0] LastIdx = CntWidth'(Width - 1);

        logic [Width-1:0]    shiftReg;
        logic [CntWidth-1:0] bitCnt;

        // payload register, lsb leaves first, new bits enter at the msb
        always_ff @(posedge ICK) begin
                if (ctrl.load) begin
                        shiftReg <= loadValue;
                end else if (ctrl.shiftEn) begin
                        shiftReg <= {ctrl.serialIn, shiftReg[Width-1:1]};
                end
        end

        // bit counter, one step per shifted bit
        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        bitCnt <= '0;
                end else if (ctrl.load) begin
                        bitCnt <= '0;
                end else if (ctrl.shiftEn) begin
                        bitCnt <= bitCnt + 1'b1;
                end
        end

        assign ctrl.serialOut = shiftReg[0];

        // high during the cycle that shifts the final bit
        assign ctrl.lastBit = (bitCnt == LastIdx);

        // after a full frame this is the captured word
        assign value = shiftReg;

endmodule

// ==== scanAccess.f ====
+incdir+common
common/scanCmdPkg.sv
common/scanLinePkg.sv
common/shiftCtrlIf.sv
rtl/scanShifter.sv
rtl/scanSequencer.sv
rtl/scanAccess.sv
test/scanTargetModel.sv
test/scanAccess_properties.sv
test/scanAccessTb.sv

// ==== test/scanAccessTb.sv ====
`timescale 1ns/1ps

`include "scan_defines.svh"

module scanAccessTb;

        localparam int DoneTimeout = 40;
        localparam int IdleTimeout = 10;

        logic               ICK;
        logic               RST;
        logic               cmdValid;
        scanCmdPkg::scanOpT cmdOp;
        scanCmdPkg::addrT   cmdAddr;
        scanCmdPkg::dataT   cmdData;
        logic               scanDi;
        logic               busy;
        logic               doneValid;
        scanCmdPkg::dataT   rspData;
        logic               scanSel;
        logic               scanDo;

        // shadow of the target memory, and of its address register
        scanCmdPkg::dataT   shadow [scanCmdPkg::addrT];
        scanCmdPkg::addrT   shadowAddr;
        // commands in flight, in issue order
        scanCmdPkg::scanOpT pendOp [$];
        scanCmdPkg::dataT   pendExp [$];

        string testName;
        int    errorCount;
        int    testErrors;
        int    testsRun;
        int    testsFailed;
        int    doneCount;

        scanAccess i_dut (
                .ICK       (ICK),
                .RST       (RST),
                .cmdValid  (cmdValid),
                .cmdOp     (cmdOp),
                .cmdAddr   (cmdAddr),
                .cmdData   (cmdData),
                .scanDi    (scanDi),
                .busy      (busy),
                .doneValid (doneValid),
                .rspData   (rspData),
                .scanSel   (scanSel),
                .scanDo    (scanDo)
        );

        scanTargetModel target (
                .ICK     (ICK),
                .RST     (RST),
                .scanSel (scanSel),
                .scanDo  (scanDo),
                .scanDi  (scanDi)
        );

        initial begin
                ICK = 1'b0;
                forever #4 ICK = ~ICK;
        end

        // unwritten words read back as zero
        function automatic scanCmdPkg::dataT expectedRead(input scanCmdPkg::addrT addr);
                if (shadow.exists(addr)) begin
                        return shadow[addr];
                end
                return '0;
        endfunction

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (expected !== actual) begin
                        errorCount++;
                        $display("error %s: expected %0h, actual %0h", name, expected, actual);
                end
        endtask

        task automatic reportFailure(input string msg);
                errorCount++;
                $display("%s: %s", testName, msg);
        endtask

        task automatic startTest(input string name);
                testName   = name;
                testErrors = errorCount;
        endtask

        task automatic finishTest();
                testsRun++;
                if (errorCount != testErrors) begin
                        testsFailed++;
                        $display("test %s failed", testName);
                end else begin
                        $display("test %s passed", testName);
                end
        endtask

        // record what the target should see and what a read should return
        task automatic noteCommand(input scanCmdPkg::scanOpT op, input scanCmdPkg::addrT addr,
                                   input scanCmdPkg::dataT data);
                pendOp.push_back(op);
                pendExp.push_back((op == scanCmdPkg::opRdData) ? expectedRead(shadowAddr) : '0);
                if (op == scanCmdPkg::opWrAddr) begin
                        shadowAddr = addr;
                end else if (op == scanCmdPkg::opWrData) begin
                        shadow[shadowAddr] = data;
                end
        endtask

        task automatic sendStrobe(input scanCmdPkg::scanOpT op, input scanCmdPkg::addrT addr,
                                  input scanCmdPkg::dataT data);
                cmdOp    = op;
                cmdAddr  = addr;
                cmdData  = data;
                cmdValid = 1'b1;
                @(posedge ICK);
                #1;
                cmdValid = 1'b0;
        endtask

        task automatic waitDone(inout int cycles);
                while (!doneValid && cycles < DoneTimeout) begin
                        @(posedge ICK);
                        #1;
                        cycles++;
                end
                if (!doneValid) begin
                        reportFailure($sformatf("no doneValid within %0d cycles", DoneTimeout));
                end
        endtask

        task automatic waitIdle();
                int n;
                n = 0;
                while (busy && n < IdleTimeout) begin
                        @(posedge ICK);
                        #1;
                        n++;
                end
                if (busy) begin
                        reportFailure("busy did not return low after the frame");
                end
        endtask

        // cycles counts edges from the one that samples the strobe
        task automatic runCommand(input scanCmdPkg::scanOpT op, input scanCmdPkg::addrT addr,
                                  input scanCmdPkg::dataT data, output int cycles);
                noteCommand(op, addr, data);
                sendStrobe(op, addr, data);
                cycles = 1;
                waitDone(cycles);
                waitIdle();
        endtask

        // checks each finished read against the reference
        always @(negedge ICK) begin : compareDone
                scanCmdPkg::scanOpT op;
                scanCmdPkg::dataT   expected;
                if (!RST && doneValid) begin
                        doneCount++;
                        if (pendOp.size() == 0) begin
                                reportFailure("doneValid seen with no command pending");
                        end else begin
                                op       = pendOp.pop_front();
                                expected = pendExp.pop_front();
                                if (op == scanCmdPkg::opRdData) begin
                                        checkValue(testName, 32'(expected), 32'(rspData));
                                end
                        end
                end
        end

        initial begin
                scanCmdPkg::addrT addrList [20];
                scanCmdPkg::addrT addr;
                scanCmdPkg::dataT data;
                int               cycles;
                int               doneBefore;

                void'($urandom(57));
                RST         = 1'b1;
                cmdValid    = 1'b0;
                cmdOp       = scanCmdPkg::opWrAddr;
                cmdAddr     = '0;
                cmdData     = '0;
                shadowAddr  = '0;
                errorCount  = 0;
                testsRun    = 0;
                testsFailed = 0;
                doneCount   = 0;
                testName    = "reset";
                repeat (5) @(posedge ICK);
                #1;
                RST = 1'b0;

                startTest("resetState");
                checkValue(testName, 0, 32'(busy));
                checkValue(testName, 0, 32'(doneValid));
                checkValue(testName, 0, 32'(scanSel));
                checkValue(testName, 0, 32'(scanDo));
                finishTest();

                startTest("writeReadBack");
                addr = scanCmdPkg::addrT'($urandom());
                data = scanCmdPkg::dataT'($urandom());
                runCommand(scanCmdPkg::opWrAddr, addr, '0, cycles);
                runCommand(scanCmdPkg::opWrData, addr, data, cycles);
                runCommand(scanCmdPkg::opWrAddr, addr, '0, cycles);
                runCommand(scanCmdPkg::opRdData, addr, '0, cycles);
                finishTest();

                startTest("manyAddresses");
                for (int i = 0; i < 20; i++) begin
                        addrList[i] = scanCmdPkg::addrT'($urandom());
                        data        = scanCmdPkg::dataT'($urandom());
                        runCommand(scanCmdPkg::opWrAddr, addrList[i], '0, cycles);
                        runCommand(scanCmdPkg::opWrData, addrList[i], data, cycles);
                end
                for (int i = 0; i < 20; i++) begin
                        runCommand(scanCmdPkg::opWrAddr, addrList[i], '0, cycles);
                        runCommand(scanCmdPkg::opRdData, addrList[i], '0, cycles);
                end
                finishTest();

                startTest("unwrittenZero");
                addr = scanCmdPkg::addrT'($urandom());
                while (shadow.exists(addr)) begin
                        addr++;
                end
                runCommand(scanCmdPkg::opWrAddr, addr, '0, cycles);
                runCommand(scanCmdPkg::opRdData, addr, '0, cycles);
                checkValue(testName, 0, 32'(rspData));
                finishTest();

                // latency counts the strobe edge, two code cycles, the payload and the end cycle
                startTest("latency");
                runCommand(scanCmdPkg::opWrAddr, addr, '0, cycles);
                checkValue(testName, 32'(4 + `SCAN_ADDR_LEN), 32'(cycles));
                runCommand(scanCmdPkg::opWrData, addr, 16'h5a3c, cycles);
                checkValue(testName, 32'(4 + `SCAN_DATA_LEN), 32'(cycles));
                runCommand(scanCmdPkg::opRdData, addr, '0, cycles);
                checkValue(testName, 32'(4 + `SCAN_DATA_LEN), 32'(cycles));
                finishTest();

                startTest("busyStrobe");
                addr = scanCmdPkg::addrT'($urandom());
                data = scanCmdPkg::dataT'($urandom());
                runCommand(scanCmdPkg::opWrAddr, addr, '0, cycles);
                runCommand(scanCmdPkg::opWrData, addr, data, cycles);
                doneBefore = doneCount;
                noteCommand(scanCmdPkg::opRdData, addr, '0);
                sendStrobe(scanCmdPkg::opRdData, addr, '0);
                repeat (3) begin
                        @(posedge ICK);
                        #1;
                end
                checkValue(testName, 1, 32'(busy));
                // this write lands mid-frame and must not reach the target
                sendStrobe(scanCmdPkg::opWrData, addr, ~data);
                cycles = 5;
                waitDone(cycles);
                waitIdle();
                repeat (30) begin
                        @(posedge ICK);
                        #1;
                end
                checkValue(testName, 1, 32'(doneCount - doneBefore));
                runCommand(scanCmdPkg::opRdData, addr, '0, cycles);
                finishTest();

                $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
                if (errorCount == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

// ==== test/scanAccess_properties.sv ====
`timescale 1ns/1ps

module scanAccessProperties (
        input logic ICK,
        input logic RST,
        input logic busy,
        input logic doneValid,
        input logic scanSel
);

        // cycles that select has been high in a row
        int selRun;

        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        selRun <= 0;
                end else if (scanSel) begin
                        selRun <= selRun + 1;
                end else begin
                        selRun <= 0;
                end
        end

        doneOneCycle: assert property (@(posedge ICK) disable iff (RST)
                doneValid |=> !doneValid)
                else $error("doneValid stayed high for more than one cycle");

        selLowAtDone: assert property (@(posedge ICK) disable iff (RST)
                doneValid |-> !scanSel)
                else $error("scanSel high while doneValid is high");

        idleAfterReset: assert property (@(posedge ICK)
                $fell(RST) |-> !busy)
                else $error("busy high right after reset");

        // a frame never keeps select high for 20 cycles
        selReleases: assert property (@(posedge ICK) disable iff (RST)
                selRun < 20)
                else $error("scanSel not released within 20 cycles");

endmodule

bind scanAccess scanAccessProperties props (
        .ICK       (ICK),
        .RST       (RST),
        .busy      (busy),
        .doneValid (doneValid),
        .scanSel   (scanSel)
);

// ==== test/scanTargetModel.sv ====
`timescale 1ns/1ps

`include "scan_defines.svh"

module scanTargetModel (
        input  logic ICK,
        input  logic RST,
        input  logic scanSel,
        input  logic scanDo,
        output logic scanDi
);

        scanCmdPkg::dataT          mem [0:(1 << `SCAN_ADDR_LEN) - 1];
        scanCmdPkg::addrT          addrReg;
        scanCmdPkg::dataT          payload;
        scanCmdPkg::dataT          replyReg;
        logic [`SCAN_CODE_LEN-1:0] code;
        int                        bitCount;

        always @(posedge ICK or posedge RST) begin
                if (RST) begin
                        for (int k = 0; k < (1 << `SCAN_ADDR_LEN); k++) begin
                                mem[k] <= '0;
                        end
                        addrReg  <= '0;
                        payload  <= '0;
                        replyReg <= '0;
                        code     <= '0;
                        bitCount <= 0;
                        scanDi   <= 1'b0;
                end else if (scanSel) begin
                        bitCount <= bitCount + 1;
                        if (bitCount < `SCAN_CODE_LEN) begin
                                code <= {scanDo, code[`SCAN_CODE_LEN-1]};
                        end else begin
                                payload <= {scanDo, payload[`SCAN_DATA_LEN-1:1]};
                        end
                        // reply starts right after the last code bit
                        if (bitCount == `SCAN_CODE_LEN - 1) begin
                                if ({scanDo, code[`SCAN_CODE_LEN-1]} == scanLinePkg::codeRdData) begin
                                        scanDi   <= mem[addrReg][0];
                                        replyReg <= mem[addrReg] >> 1;
                                end
                        end else if (bitCount >= `SCAN_CODE_LEN &&
                                     code == scanLinePkg::codeRdData) begin
                                scanDi   <= replyReg[0];
                                replyReg <= replyReg >> 1;
                        end
                end else if (bitCount != 0) begin
                        // select dropped, so the frame is complete
                        bitCount <= 0;
                        scanDi   <= 1'b0;
                        case (code)
                                scanLinePkg::codeWrAddr: begin
                                        addrReg <= payload[`SCAN_DATA_LEN-1 -: `SCAN_ADDR_LEN];
                                end
                                scanLinePkg::codeWrData: mem[addrReg] <= payload;
                                default: ;
                        endcase
                end
        end

endmodule
